// ==== src/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    // Request from execute on each strobe
    typedef struct packed {
        mem_op_e     op;
        mem_size_e   size;
        logic        is_unsigned;
        logic [4:0]  rd;
        logic [31:0] addr;
        logic [31:0] store_data;
        logic [31:0] alu_result;
    } ex_to_lsu_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic        we;
        logic [31:0] data;
    } lsu_to_wb_t;

    // RAM window seen by the slave
    localparam logic [31:0] RAM_BASE  = 32'h8000_0000;
    localparam int          RAM_WORDS = 256;
    localparam int          RAM_AW    = $clog2(RAM_WORDS);
    localparam logic [31:0] RAM_LIMIT = RAM_BASE + 32'(RAM_WORDS * 4);

endpackage

`default_nettype wire

// ==== src/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

    // Single-beat channels without id, len or burst
    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [2:0]  size;
    } axi_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam logic [2:0] SIZE_BYTE = 3'h0;
    localparam logic [2:0] SIZE_HALF = 3'h1;
    localparam logic [2:0] SIZE_WORD = 3'h2;

    // Extra slave cycles before AR/AW acceptance
    localparam int MEM_WAIT   = 2;
    localparam int MEM_WAIT_W = $clog2(MEM_WAIT + 1);

endpackage

`default_nettype wire

// ==== src/lsu_req_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_req_decode (
    input  lsu_pkg::ex_to_lsu_t req,
    output logic [2:0]          axi_size,
    output logic [3:0]          w_strb,
    output logic [31:0]         w_data
);

    logic [1:0] offset;
    logic [3:0] strb_base;

    assign offset = req.addr[1:0];

    always_comb begin
        case (req.size)
            lsu_pkg::MEM_BYTE: begin
                axi_size  = axi_pkg::SIZE_BYTE;
                strb_base = 4'b0001;
            end
            lsu_pkg::MEM_HALF: begin
                axi_size  = axi_pkg::SIZE_HALF;
                strb_base = 4'b0011;
            end
            default: begin
                axi_size  = axi_pkg::SIZE_WORD;
                strb_base = 4'b1111;
            end
        endcase
    end

    // Lanes follow the byte offset
    assign w_strb = strb_base << offset;
    assign w_data = req.store_data << {offset, 3'b000};

    // No split transfers, so every memory access must be naturally aligned
    always_comb begin
        if (req.op != lsu_pkg::MEM_NONE) begin
            assert ((req.size != lsu_pkg::MEM_HALF || req.addr[0] == 1'b0) &&
                    (req.size != lsu_pkg::MEM_WORD || req.addr[1:0] == 2'b00))
            else $error("misaligned access addr=%h size=%0d", req.addr, req.size);
        end
    end

endmodule

`default_nettype wire

// ==== src/lsu_load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
    input  logic [31:0]        r_data,
    input  logic [1:0]         offset,
    input  lsu_pkg::mem_size_e size,
    input  logic               is_unsigned,
    output logic [31:0]        load_data
);

    logic [31:0] shifted;

    assign shifted = r_data >> {offset, 3'b000};  // Addressed byte to lane 0

    always_comb begin
        case (size)
            lsu_pkg::MEM_BYTE: begin
                if (is_unsigned) begin
                    load_data = {24'b0, shifted[7:0]};
                end else begin
                    load_data = {{24{shifted[7]}}, shifted[7:0]};
                end
            end
            lsu_pkg::MEM_HALF: begin
                if (is_unsigned) begin
                    load_data = {16'b0, shifted[15:0]};
                end else begin
                    load_data = {{16{shifted[15]}}, shifted[15:0]};
                end
            end
            default: load_data = shifted;  // Word access at offset zero
        endcase
    end

endmodule

`default_nettype wire

// ==== src/lsu_axi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_axi_master (
    input  logic                clk,
    input  logic                rst,
    input  logic                exu_valid,
    input  lsu_pkg::ex_to_lsu_t ex_req,
    input  logic [2:0]          axi_size,
    input  logic [3:0]          w_strb,
    input  logic [31:0]         w_data,
    input  logic [31:0]         load_data,
    output logic                lsu_ready,
    output logic                lsu_valid,
    output lsu_pkg::lsu_to_wb_t wb,
    output logic                access_fault,
    output axi_pkg::axi_ar_t    ar,
    output logic                ar_valid,
    input  logic                ar_ready,
    output axi_pkg::axi_aw_t    aw,
    output axi_pkg::axi_w_t     w,
    output logic                aw_valid,
    output logic                w_valid,
    input  logic                aw_ready,
    input  logic                w_ready,
    input  axi_pkg::axi_r_t     r,
    input  logic                r_valid,
    output logic                r_ready,
    input  axi_pkg::axi_b_t     b,
    input  logic                b_valid,
    output logic                b_ready
);

    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } state_e;

    state_e     state;
    logic [4:0] rd_q;
    logic       accept;
    logic       ar_done;
    logic       wr_done;
    logic       r_done;
    logic       b_done;

    assign lsu_ready = (state == IDLE);
    assign accept    = exu_valid && lsu_ready;
    assign ar_done   = ar_valid && ar_ready;
    assign wr_done   = aw_valid && aw_ready && w_valid && w_ready;  // AW and W go together
    assign r_done    = r_valid && r_ready;
    assign b_done    = b_valid && b_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= IDLE;
            lsu_valid    <= 1'b0;
            access_fault <= 1'b0;
            ar_valid     <= 1'b0;
            aw_valid     <= 1'b0;
            w_valid      <= 1'b0;
            r_ready      <= 1'b0;
            b_ready      <= 1'b0;
        end else begin
            lsu_valid    <= 1'b0;
            access_fault <= 1'b0;
            case (state)
                IDLE: begin
                    if (exu_valid) begin
                        case (ex_req.op)
                            lsu_pkg::MEM_LOAD: begin
                                ar_valid <= 1'b1;
                                state    <= BUSY;
                            end
                            lsu_pkg::MEM_STORE: begin
                                aw_valid <= 1'b1;
                                w_valid  <= 1'b1;
                                state    <= BUSY;
                            end
                            default: lsu_valid <= 1'b1;  // Bypass with the alu result
                        endcase
                    end
                end
                BUSY: begin
                    if (ar_done) begin
                        ar_valid <= 1'b0;
                        r_ready  <= 1'b1;
                    end
                    if (wr_done) begin
                        aw_valid <= 1'b0;
                        w_valid  <= 1'b0;
                        b_ready  <= 1'b1;
                    end
                    if (r_done) begin
                        r_ready      <= 1'b0;
                        lsu_valid    <= 1'b1;
                        access_fault <= (r.resp != axi_pkg::RESP_OKAY);
                        state        <= IDLE;
                    end
                    if (b_done) begin
                        b_ready      <= 1'b0;
                        lsu_valid    <= 1'b1;
                        access_fault <= (b.resp != axi_pkg::RESP_OKAY);
                        state        <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request payload captured on the strobe
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_q    <= ex_req.rd;
            ar.addr <= ex_req.addr;
            ar.size <= axi_size;
            aw.addr <= ex_req.addr;
            aw.size <= axi_size;
            w.data  <= w_data;
            w.strb  <= w_strb;
        end
    end

    // Write-back result
    always_ff @(posedge clk) begin
        if (accept && ex_req.op == lsu_pkg::MEM_NONE) begin
            wb.rd   <= ex_req.rd;
            wb.we   <= 1'b1;
            wb.data <= ex_req.alu_result;
        end else if (r_done) begin
            wb.rd   <= rd_q;
            wb.we   <= 1'b1;
            wb.data <= (r.resp == axi_pkg::RESP_OKAY) ? load_data : 32'h0;
        end else if (b_done) begin
            wb.rd   <= rd_q;
            wb.we   <= 1'b0;  // Stores never write a register
            wb.data <= 32'h0;
        end
    end

    a_no_strobe_busy: assert property (@(posedge clk) disable iff (rst)
        exu_valid |-> lsu_ready);

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar));

    a_wr_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid && !aw_ready |=> aw_valid && w_valid && $stable(aw) && $stable(w));

    // Aligner works from the live request, so its fields must hold until done
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        state == BUSY |-> $stable({ex_req.addr[1:0], ex_req.size, ex_req.is_unsigned}));

endmodule

`default_nettype wire

// ==== src/axi_sram_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_sram_slave (
    input  logic             clk,
    input  logic             rst,
    input  axi_pkg::axi_ar_t ar,
    input  logic             ar_valid,
    output logic             ar_ready,
    input  axi_pkg::axi_aw_t aw,
    input  axi_pkg::axi_w_t  w,
    input  logic             aw_valid,
    input  logic             w_valid,
    output logic             aw_ready,
    output logic             w_ready,
    output axi_pkg::axi_r_t  r,
    output logic             r_valid,
    input  logic             r_ready,
    output axi_pkg::axi_b_t  b,
    output logic             b_valid,
    input  logic             b_ready
);

    logic [31:0] mem [lsu_pkg::RAM_WORDS];

    logic [axi_pkg::MEM_WAIT_W-1:0] cnt;
    logic                           free;
    logic                           rd_req;
    logic                           wr_req;
    logic                           ar_hit;
    logic                           aw_hit;
    logic [lsu_pkg::RAM_AW-1:0]     ar_idx;
    logic [lsu_pkg::RAM_AW-1:0]     aw_idx;

    assign rd_req = ar_valid;
    assign wr_req = aw_valid && w_valid;
    assign free   = !ar_ready && !aw_ready && !r_valid && !b_valid;  // Nothing in flight

    assign ar_hit = (ar.addr >= lsu_pkg::RAM_BASE) && (ar.addr < lsu_pkg::RAM_LIMIT);
    assign aw_hit = (aw.addr >= lsu_pkg::RAM_BASE) && (aw.addr < lsu_pkg::RAM_LIMIT);
    assign ar_idx = ar.addr[lsu_pkg::RAM_AW+1:2];
    assign aw_idx = aw.addr[lsu_pkg::RAM_AW+1:2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt      <= '0;
            ar_ready <= 1'b0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            r_valid  <= 1'b0;
            b_valid  <= 1'b0;
        end else begin
            ar_ready <= 1'b0;  // Ready is a one-cycle pulse
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            if (r_valid && r_ready) r_valid <= 1'b0;
            if (b_valid && b_ready) b_valid <= 1'b0;
            if (ar_valid && ar_ready) r_valid <= 1'b1;
            if (aw_valid && aw_ready) b_valid <= 1'b1;
            if (free && (rd_req || wr_req)) begin
                if (cnt == axi_pkg::MEM_WAIT_W'(axi_pkg::MEM_WAIT - 1)) begin
                    cnt <= '0;
                    if (rd_req) begin
                        ar_ready <= 1'b1;
                    end else begin
                        aw_ready <= 1'b1;
                        w_ready  <= 1'b1;
                    end
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            r.data <= ar_hit ? mem[ar_idx] : 32'h0;
            r.resp <= ar_hit ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
        end
        if (aw_valid && aw_ready) begin
            b.resp <= aw_hit ? axi_pkg::RESP_OKAY : axi_pkg::RESP_SLVERR;
            if (aw_hit) begin
                for (int i = 0; i < 4; i++) begin
                    if (w.strb[i]) mem[aw_idx][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

    a_aw_w_together: assert property (@(posedge clk) disable iff (rst)
        aw_valid == w_valid);

endmodule

`default_nettype wire

// ==== src/lsu_sys.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_sys (
    input  logic                clk,
    input  logic                rst,
    input  logic                exu_valid,
    input  lsu_pkg::ex_to_lsu_t ex_req,
    output logic                lsu_ready,
    output logic                lsu_valid,
    output lsu_pkg::lsu_to_wb_t wb,
    output logic                access_fault
);

    logic [2:0]       axi_size;
    logic [3:0]       w_strb;
    logic [31:0]      w_data;
    logic [31:0]      load_data;
    axi_pkg::axi_ar_t ar;
    axi_pkg::axi_aw_t aw;
    axi_pkg::axi_w_t  w;
    axi_pkg::axi_r_t  r;
    axi_pkg::axi_b_t  b;
    logic             ar_valid;
    logic             ar_ready;
    logic             aw_valid;
    logic             aw_ready;
    logic             w_valid;
    logic             w_ready;
    logic             r_valid;
    logic             r_ready;
    logic             b_valid;
    logic             b_ready;

    lsu_req_decode i_decode (
        .req      (ex_req),
        .axi_size (axi_size),
        .w_strb   (w_strb),
        .w_data   (w_data)
    );

    // ex_req stays on the bus until lsu_valid, so the aligner reads it directly
    lsu_load_align i_align (
        .r_data      (r.data),
        .offset      (ex_req.addr[1:0]),
        .size        (ex_req.size),
        .is_unsigned (ex_req.is_unsigned),
        .load_data   (load_data)
    );

    lsu_axi_master i_master (
        .clk          (clk),
        .rst          (rst),
        .exu_valid    (exu_valid),
        .ex_req       (ex_req),
        .axi_size     (axi_size),
        .w_strb       (w_strb),
        .w_data       (w_data),
        .load_data    (load_data),
        .lsu_ready    (lsu_ready),
        .lsu_valid    (lsu_valid),
        .wb           (wb),
        .access_fault (access_fault),
        .ar           (ar),
        .ar_valid     (ar_valid),
        .ar_ready     (ar_ready),
        .aw           (aw),
        .w            (w),
        .aw_valid     (aw_valid),
        .w_valid      (w_valid),
        .aw_ready     (aw_ready),
        .w_ready      (w_ready),
        .r            (r),
        .r_valid      (r_valid),
        .r_ready      (r_ready),
        .b            (b),
        .b_valid      (b_valid),
        .b_ready      (b_ready)
    );

    axi_sram_slave i_sram (
        .clk      (clk),
        .rst      (rst),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .aw       (aw),
        .w        (w),
        .aw_valid (aw_valid),
        .w_valid  (w_valid),
        .aw_ready (aw_ready),
        .w_ready  (w_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready)
    );

endmodule

`default_nettype wire

// ==== sim/tb_lsu_sys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_sys;

    localparam int FIELDS    = 9;  // Words per line of the case file
    localparam int MAX_CASES = 32;
    localparam int TIMEOUT   = 40;

    logic                clk;
    logic                rst;
    logic                exu_valid;
    lsu_pkg::ex_to_lsu_t ex_req;
    logic                lsu_ready;
    logic                lsu_valid;
    lsu_pkg::lsu_to_wb_t wb;
    logic                access_fault;

    logic [31:0] cases [MAX_CASES*FIELDS];
    int          errors;
    int          timeouts;
    int          num_cases;
    integer      seed;

    lsu_sys i_lsu_sys (
        .clk          (clk),
        .rst          (rst),
        .exu_valid    (exu_valid),
        .ex_req       (ex_req),
        .lsu_ready    (lsu_ready),
        .lsu_valid    (lsu_valid),
        .wb           (wb),
        .access_fault (access_fault)
    );

    always #20 clk = ~clk;

    task automatic check_wb(input lsu_pkg::lsu_to_wb_t got, input lsu_pkg::lsu_to_wb_t want);
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t wb got rd=%0d we=%b data=%h, expected rd=%0d we=%b data=%h",
                     $time, got.rd, got.we, got.data, want.rd, want.we, want.data);
        end
    endtask

    task automatic check_fault(input logic got, input logic want);
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t access_fault got %b, expected %b", $time, got, want);
        end
    endtask

    // Handshake levels on the pipeline side
    task automatic check_level(input string name, input logic got, input logic want);
        if (got !== want) begin
            errors++;
            $display("[FAIL] %0t %s got %b, expected %b", $time, name, got, want);
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (lsu_ready !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (lsu_ready !== 1'b1) begin
            timeouts++;
            $display("Timeout at %0t: the LSU never became ready for a new request", $time);
        end
    endtask

    task automatic run_case(input int idx);
        lsu_pkg::ex_to_lsu_t req;
        lsu_pkg::lsu_to_wb_t want_wb;
        logic                want_fault;
        int                  base;
        int                  gap;
        int                  n;
        base            = idx * FIELDS;
        req.op          = lsu_pkg::mem_op_e'(cases[base][1:0]);
        req.size        = lsu_pkg::mem_size_e'(cases[base+1][1:0]);
        req.is_unsigned = cases[base+2][0];
        req.rd          = cases[base+3][4:0];
        req.addr        = cases[base+4];
        req.store_data  = cases[base+5];
        req.alu_result  = cases[base+6];
        want_wb.rd      = req.rd;
        want_wb.we      = (req.op != lsu_pkg::MEM_STORE);  // Stores write no register
        want_wb.data    = cases[base+7];
        want_fault      = cases[base+8][0];

        wait_ready();
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        ex_req    <= req;
        exu_valid <= 1'b1;
        @(posedge clk);
        exu_valid <= 1'b0;
        @(negedge clk);

        if (req.op == lsu_pkg::MEM_NONE) begin
            check_level("lsu_valid", lsu_valid, 1'b1);  // Exactly one cycle later
        end else begin
            n = 0;
            while (lsu_valid !== 1'b1 && n < TIMEOUT) begin
                check_level("lsu_ready", lsu_ready, 1'b0);
                @(negedge clk);
                n++;
            end
        end

        if (lsu_valid !== 1'b1) begin
            timeouts++;
            $display("Timeout at %0t: no result came back for case %0d", $time, idx);
        end else begin
            check_level("lsu_ready", lsu_ready, 1'b1);
            check_wb(wb, want_wb);
            check_fault(access_fault, want_fault);
            @(negedge clk);
            check_level("lsu_valid", lsu_valid, 1'b0);  // Single-cycle pulse
            check_level("lsu_ready", lsu_ready, 1'b1);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        exu_valid = 1'b0;
        ex_req    = '0;
        errors    = 0;
        timeouts  = 0;
        num_cases = 0;
        seed      = 11890;
        for (int i = 0; i < MAX_CASES * FIELDS; i++) begin
            cases[i] = '1;
        end
        $readmemh("sim/lsu_cases.txt", cases);
        while (num_cases < MAX_CASES && cases[num_cases * FIELDS] !== 32'hFFFF_FFFF) begin
            num_cases++;
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        check_level("lsu_ready", lsu_ready, 1'b1);
        check_level("lsu_valid", lsu_valid, 1'b0);
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        if (num_cases == 0) begin
            errors++;
            $display("No cases were loaded from sim/lsu_cases.txt");
        end
        for (int i = 0; i < num_cases; i++) begin
            run_case(i);
        end

        $display("Cases: %0d, errors: %0d, timeouts: %0d", num_cases, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== lsu_sys.f ====
src/lsu_pkg.sv
src/axi_pkg.sv
src/lsu_req_decode.sv
src/lsu_load_align.sv
src/lsu_axi_master.sv
src/axi_sram_slave.sv
src/lsu_sys.sv
sim/tb_lsu_sys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f lsu_sys.f --top-module tb_lsu_sys \
    -o tb_lsu_sys \
    && ./obj_dir/tb_lsu_sys > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "Done: no errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== sim/lsu_cases.txt ====
// op size unsigned rd addr store_data alu_result exp_data exp_fault
// op 0 none 1 load 2 store, size 0 byte 1 half 2 word
2 2 0 05 80000010 12345678 00000000 00000000 0
1 2 0 06 80000010 00000000 00000000 12345678 0
2 2 0 01 80000020 AABBCCDD 00000000 00000000 0
2 0 0 01 80000021 777777EE 00000000 00000000 0
2 1 0 01 80000022 12348001 00000000 00000000 0
1 2 0 07 80000020 00000000 00000000 8001EEDD 0
1 0 0 08 80000021 00000000 00000000 FFFFFFEE 0
1 0 1 09 80000021 00000000 00000000 000000EE 0
1 1 0 0A 80000022 00000000 00000000 FFFF8001 0
1 1 1 0B 80000022 00000000 00000000 00008001 0
1 0 0 0C 80000013 00000000 00000000 00000012 0
1 1 0 0D 80000010 00000000 00000000 00005678 0
0 0 0 0E 00000000 00000000 CAFE0001 CAFE0001 0
2 2 0 02 80000000 11223344 00000000 00000000 0
2 2 0 03 80000400 CAFEF00D 00000000 00000000 1
2 2 0 03 00001000 DEADBEEF 00000000 00000000 1
1 2 0 0F 7FFFFFFC 00000000 00000000 00000000 1
1 2 0 10 80000000 00000000 00000000 11223344 0
0 0 0 11 00000000 00000000 0000ABCD 0000ABCD 0
